// ==== aesParamsPkg.sv ====
package aesParamsPkg;

    // ********************************************************************
    // sizes for AES-128
    // ********************************************************************
    localparam int BlockBits     = 128;
    localparam int WordBits      = 32;
    localparam int NumRounds     = 10;
    localparam int KeyWords      = 4;
    localparam int ScheduleWords = 4 * (NumRounds + 1);

    // byte 0 of the state sits in the top bits, columns follow in order
    typedef logic [BlockBits-1:0] aesBlockT;
    typedef logic [WordBits-1:0]  aesWordT;

    // one block per round, index is the round number
    typedef aesBlockT [NumRounds:0] roundKeysT;

    typedef struct packed {
        logic     valid;
        aesBlockT data;
    } aesStageT;

    typedef enum logic [1:0] {
        keyIdle,
        keyExpand,
        keyDone
    } keyStateT;

endpackage

// ==== aesMathPkg.sv ====
package aesMathPkg;

    // ********************************************************************
    // lookup tables, entry 0 is the leftmost byte
    // ********************************************************************
    localparam logic [0:255][7:0] sBox = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    localparam logic [0:255][7:0] invSBox = {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    localparam logic [0:9][7:0] roundConst = 80'h01020408102040801b36;

    // first row of the inverse MixColumns matrix, later rows are rotations
    localparam logic [0:3][3:0] invMixCoef = {4'he, 4'hb, 4'hd, 4'h9};

    // ********************************************************************
    // field arithmetic and block transforms
    // ********************************************************************
    function automatic logic [7:0] xTime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gfMul(input logic [7:0] b, input logic [3:0] m);
        logic [7:0] x2;
        logic [7:0] x4;
        logic [7:0] x8;
        x2 = xTime(b);
        x4 = xTime(x2);
        x8 = xTime(x4);
        case (m)
            4'h9:    return x8 ^ b;
            4'hb:    return x8 ^ x2 ^ b;
            4'hd:    return x8 ^ x4 ^ b;
            4'he:    return x8 ^ x4 ^ x2;
            default: return b;
        endcase
    endfunction

    function automatic aesParamsPkg::aesBlockT invShiftRows(input aesParamsPkg::aesBlockT s);
        aesParamsPkg::aesBlockT r;
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                // row n turns right by n columns
                r[8*(15 - (4*c + row)) +: 8] = s[8*(15 - (4*((c - row + 4) % 4) + row)) +: 8];
            end
        end
        return r;
    endfunction

    function automatic aesParamsPkg::aesBlockT invSubBytes(input aesParamsPkg::aesBlockT s);
        aesParamsPkg::aesBlockT r;
        for (int i = 0; i < 16; i++) begin
            r[8*i +: 8] = invSBox[s[8*i +: 8]];
        end
        return r;
    endfunction

    function automatic aesParamsPkg::aesBlockT invMixColumns(input aesParamsPkg::aesBlockT s);
        aesParamsPkg::aesBlockT r;
        logic [7:0] acc;
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                acc = 8'h00;
                for (int k = 0; k < 4; k++) begin
                    acc ^= gfMul(s[8*(15 - (4*c + k)) +: 8], invMixCoef[(k - row + 4) % 4]);
                end
                r[8*(15 - (4*c + row)) +: 8] = acc;
            end
        end
        return r;
    endfunction

    function automatic aesParamsPkg::aesWordT subWord(input aesParamsPkg::aesWordT w);
        return {sBox[w[31:24]], sBox[w[23:16]], sBox[w[15:8]], sBox[w[7:0]]};
    endfunction

    function automatic aesParamsPkg::aesWordT rotWord(input aesParamsPkg::aesWordT w);
        return {w[23:0], w[31:24]};
    endfunction

endpackage

// ==== aesKeySchedule.sv ====
`timescale 1ns/1ps

module aesKeySchedule (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    keyLoad,
    input  aesParamsPkg::aesBlockT  key,
    output aesParamsPkg::roundKeysT roundKeys,
    output logic                    keyReady
);
    import aesParamsPkg::*;
    import aesMathPkg::*;

    keyStateT   keyState;
    logic [5:0] wordIdx;
    // last four words, oldest in the top bits
    aesBlockT   window;
    aesWordT    tempWord;
    aesWordT    nextWord;

    // ********************************************************************
    // next word from w[i-4] and w[i-1]
    // ********************************************************************
    always_comb begin
        tempWord = window[WordBits-1:0];
        if (wordIdx[1:0] == 2'b00) begin
            tempWord = subWord(rotWord(tempWord)) ^ {roundConst[wordIdx[5:2] - 4'd1], 24'h000000};
        end
        nextWord = window[BlockBits-1 -: WordBits] ^ tempWord;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            keyState  <= keyIdle;
            wordIdx   <= '0;
            roundKeys <= '0;
        end else if (keyLoad) begin
            keyState     <= keyExpand;
            wordIdx      <= 6'(KeyWords);
            roundKeys[0] <= key;
        end else begin
            case (keyState)
                keyExpand: begin
                    roundKeys[wordIdx[5:2]][(2'd3 - wordIdx[1:0]) * WordBits +: WordBits]
                        <= nextWord;
                    wordIdx <= wordIdx + 6'd1;
                    if (wordIdx == 6'(ScheduleWords - 1)) begin
                        keyState <= keyDone;
                    end
                end
                // idle and done hold until the next load
                default: keyState <= keyState;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (keyLoad) begin
            window <= key;
        end else if (keyState == keyExpand) begin
            window <= {window[BlockBits-WordBits-1:0], nextWord};
        end
    end

    assign keyReady = (keyState == keyDone);

endmodule

// ==== aesInvRound.sv ====
`timescale 1ns/1ps

module aesInvRound #(
    parameter bit LastRound = 1'b0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  aesParamsPkg::aesStageT stageIn,
    input  aesParamsPkg::aesBlockT roundKey,
    output aesParamsPkg::aesStageT stageOut
);
    import aesParamsPkg::*;
    import aesMathPkg::*;

    aesBlockT roundData;

    always_comb begin
        roundData = invSubBytes(invShiftRows(stageIn.data)) ^ roundKey;
        // the final round skips the column mix
        if (!LastRound) begin
            roundData = invMixColumns(roundData);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stageOut.valid <= 1'b0;
        end else begin
            stageOut.valid <= stageIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        stageOut.data <= roundData;
    end

endmodule

// ==== aesInvPipeline.sv ====
`timescale 1ns/1ps

module aesInvPipeline (
    input  logic                    clk,
    input  logic                    rst_n,
    input  aesParamsPkg::aesStageT  stageIn,
    input  aesParamsPkg::roundKeysT roundKeys,
    output aesParamsPkg::aesStageT  stageOut
);
    import aesParamsPkg::*;

    aesStageT initStage;
    aesStageT stageChain [0:NumRounds];

    // ********************************************************************
    // initial round, add the last round key
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            initStage.valid <= 1'b0;
        end else begin
            initStage.valid <= stageIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        initStage.data <= stageIn.data ^ roundKeys[NumRounds];
    end

    assign stageChain[0] = initStage;

    // ********************************************************************
    // round stages, keys taken in reverse order
    // ********************************************************************
    for (genvar r = 1; r <= NumRounds; r++) begin : gRound
        aesInvRound #(
            .LastRound (r == NumRounds)
        ) uRound (
            .clk      (clk),
            .rst_n    (rst_n),
            .stageIn  (stageChain[r-1]),
            .roundKey (roundKeys[NumRounds-r]),
            .stageOut (stageChain[r])
        );
    end

    assign stageOut = stageChain[NumRounds];

endmodule

// ==== aesInvTop.sv ====
`timescale 1ns/1ps

module aesInvTop (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   keyLoad,
    input  aesParamsPkg::aesBlockT key,
    output logic                   keyReady,
    input  logic                   validIn,
    input  aesParamsPkg::aesBlockT dataIn,
    output logic                   validOut,
    output aesParamsPkg::aesBlockT dataOut
);
    import aesParamsPkg::*;

    roundKeysT roundKeys;
    aesStageT  stageIn;
    aesStageT  stageOut;

    aesKeySchedule uKeySchedule (
        .clk       (clk),
        .rst_n     (rst_n),
        .keyLoad   (keyLoad),
        .key       (key),
        .roundKeys (roundKeys),
        .keyReady  (keyReady)
    );

    assign stageIn = '{valid: validIn, data: dataIn};

    aesInvPipeline uPipeline (
        .clk       (clk),
        .rst_n     (rst_n),
        .stageIn   (stageIn),
        .roundKeys (roundKeys),
        .stageOut  (stageOut)
    );

    assign validOut = stageOut.valid;
    assign dataOut  = stageOut.data;

endmodule

// ==== aesInvClockGen.sv ====
`timescale 1ns/1ps

module aesInvClockGen #(
    parameter int PeriodNs    = 20,
    parameter int ResetCycles = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    // release lines up with the input drive delay of the testbench
    initial begin
        rst_n = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

// ==== aesInv_assertions.sv ====
`timescale 1ns/1ps

module aesInvChecks (
    input logic clk,
    input logic rst_n,
    input logic keyLoad,
    input logic keyReady,
    input logic validIn,
    input logic validOut
);
    import aesParamsPkg::*;

    localparam int Latency      = NumRounds + 1;
    localparam int ExpandCycles = ScheduleWords - KeyWords;
    // keyReady is set on the last expand edge and sampled one edge later
    localparam int ReadyDelay   = ExpandCycles + 1;

    int failCount = 0;

    // blocks enter only with a complete key schedule
    validNeedsKey: assert property (@(posedge clk) disable iff (!rst_n)
        validIn |-> keyReady)
        else begin
            failCount++;
            $error("validIn asserted while keyReady is low");
        end

    outputLatency: assert property (@(posedge clk) disable iff (!rst_n)
        validOut == $past(validIn, Latency))
        else begin
            failCount++;
            $error("validOut does not follow validIn by %0d cycles", Latency);
        end

    loadClearsReady: assert property (@(posedge clk) disable iff (!rst_n)
        keyLoad |=> !keyReady)
        else begin
            failCount++;
            $error("keyReady still high after keyLoad");
        end

    readyAfterExpand: assert property (@(posedge clk) disable iff (!rst_n)
        $past(keyLoad, ReadyDelay) |-> keyReady)
        else begin
            failCount++;
            $error("keyReady not high %0d cycles after keyLoad", ExpandCycles);
        end

    readyNotEarly: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(keyReady) |-> $past(keyLoad, ReadyDelay))
        else begin
            failCount++;
            $error("keyReady rose at the wrong time after keyLoad");
        end

    // reset is synchronous so outputs go low one edge later
    resetQuiet: assert property (@(posedge clk)
        !rst_n |=> (!keyReady && !validOut))
        else begin
            failCount++;
            $error("keyReady or validOut high during reset");
        end

endmodule

bind aesInvTop aesInvChecks uChecks (
    .clk      (clk),
    .rst_n    (rst_n),
    .keyLoad  (keyLoad),
    .keyReady (keyReady),
    .validIn  (validIn),
    .validOut (validOut)
);

// ==== aesInvTb.sv ====
`timescale 1ns/1ps

module aesInvTb;
    import aesParamsPkg::*;

    localparam int ClkPeriod    = 20;
    localparam int ResetCycles  = 5;
    localparam int DriveDelay   = 2;
    localparam int Seed         = 88342;
    localparam int Latency      = NumRounds + 1;
    localparam int ExpandCycles = ScheduleWords - KeyWords;
    localparam int StreamCycles = 40;
    // reset, three key loads, three single blocks and the stream plus slack for each
    localparam int TestCycles   = ResetCycles + 3 * (ExpandCycles + 6)
                                + 3 * (3 * Latency + 6) + StreamCycles + 3 * Latency;

    localparam aesBlockT Key1    = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aesBlockT Cipher1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam aesBlockT Plain1  = 128'h00112233445566778899aabbccddeeff;
    localparam aesBlockT Key2    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam aesBlockT Cipher2 = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam aesBlockT Plain2  = 128'h3243f6a8885a308d313198a2e0370734;

    logic     clk;
    logic     rst_n;
    logic     keyLoad;
    logic     keyReady;
    logic     validIn;
    logic     validOut;
    aesBlockT key;
    aesBlockT dataIn;
    aesBlockT dataOut;

    aesBlockT expectQ[$];
    int       errorCount = 0;
    int       inCount    = 0;
    int       outCount   = 0;

    aesInvClockGen #(
        .PeriodNs    (ClkPeriod),
        .ResetCycles (ResetCycles)
    ) uClockGen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    aesInvTop dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .keyLoad  (keyLoad),
        .key      (key),
        .keyReady (keyReady),
        .validIn  (validIn),
        .dataIn   (dataIn),
        .validOut (validOut),
        .dataOut  (dataOut)
    );

    // ********************************************************************
    // helpers
    // ********************************************************************
    task automatic checkValue(input string name, input logic [BlockBits-1:0] expected,
                              input logic [BlockBits-1:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic nextCycle;
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic sendBlock(input aesBlockT cipher, input aesBlockT plain);
        validIn = 1'b1;
        dataIn  = cipher;
        expectQ.push_back(plain);
        inCount++;
    endtask

    // junk on dataIn shows that bubbles are ignored
    task automatic idleInput;
        validIn = 1'b0;
        dataIn  = {$urandom, $urandom, $urandom, $urandom};
    endtask

    task automatic waitDrain;
        int cycles;
        cycles = 0;
        while (expectQ.size() != 0 && cycles < 2 * Latency) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (expectQ.size() != 0) begin
            reportFailure("pipeline did not drain, blocks still missing");
        end
    endtask

    task automatic loadKey(input aesBlockT newKey, output int cycles);
        logic ready;
        nextCycle;
        keyLoad = 1'b1;
        key     = newKey;
        nextCycle;
        keyLoad = 1'b0;
        ready   = 1'b0;
        cycles  = -1;
        // negedge number k after the load edge shows the state k edges later
        while (!ready && cycles < 2 * ExpandCycles) begin
            @(negedge clk);
            cycles++;
            if (cycles == 0) begin
                checkValue("keyReady", 1'b0, keyReady);
            end
            ready = keyReady;
        end
        if (!ready) begin
            reportFailure("keyReady never rose after the key load");
        end
    endtask

    // output pairing against the expectation queue
    always @(negedge clk) begin
        if (rst_n && validOut) begin
            outCount++;
            if (expectQ.size() == 0) begin
                reportFailure("validOut pulsed with no block in flight");
            end else begin
                checkValue("dataOut", expectQ.pop_front(), dataOut);
            end
        end
    end

    // ********************************************************************
    // tests
    // ********************************************************************
    task automatic checkResetState;
        repeat (ResetCycles - 1) begin
            @(negedge clk);
            checkValue("keyReady", 1'b0, keyReady);
            checkValue("validOut", 1'b0, validOut);
        end
        wait (rst_n === 1'b1);
        repeat (2) begin
            @(negedge clk);
            checkValue("keyReady", 1'b0, keyReady);
            checkValue("validOut", 1'b0, validOut);
        end
    endtask

    task automatic keyExpansionTiming;
        int cycles;
        loadKey(Key1, cycles);
        checkValue("keyReady latency", ExpandCycles, cycles);
    endtask

    task automatic decryptSingle(input aesBlockT cipher, input aesBlockT plain);
        int i;
        nextCycle;
        sendBlock(cipher, plain);
        nextCycle;
        validIn = 1'b0;
        // negedge i falls in the i-th cycle after the one that carried validIn
        for (i = 1; i <= Latency + 2; i++) begin
            @(negedge clk);
            checkValue("validOut", (i == Latency), validOut);
        end
        waitDrain;
    endtask

    task automatic streamWithBubbles;
        int i;
        int startIn;
        int startOut;
        startIn  = inCount;
        startOut = outCount;
        for (i = 0; i < StreamCycles; i++) begin
            nextCycle;
            // a back-to-back burst first, then random gaps
            if (i < 6 || ($urandom & 1)) begin
                sendBlock(Cipher1, Plain1);
            end else begin
                idleInput;
            end
        end
        nextCycle;
        idleInput;
        waitDrain;
        checkValue("validOut count", inCount - startIn, outCount - startOut);
    endtask

    task automatic keyReload;
        int cycles;
        loadKey(Key2, cycles);
        checkValue("keyReady latency", ExpandCycles, cycles);
        decryptSingle(Cipher2, Plain2);
        loadKey(Key1, cycles);
        checkValue("keyReady latency", ExpandCycles, cycles);
        decryptSingle(Cipher1, Plain1);
    endtask

    initial begin
        void'($urandom(Seed));
        keyLoad = 1'b0;
        key     = '0;
        validIn = 1'b0;
        dataIn  = '0;
        checkResetState;
        keyExpansionTiming;
        decryptSingle(Cipher1, Plain1);
        streamWithBubbles;
        keyReload;
        errorCount += dut.uChecks.failCount;
        $display("Run complete with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(2 * TestCycles * ClkPeriod);
        $display("Error at %0t: simulation timed out before the tests finished", $time);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== files.f ====
aesParamsPkg.sv
aesMathPkg.sv
aesKeySchedule.sv
aesInvRound.sv
aesInvPipeline.sv
aesInvTop.sv
aesInvClockGen.sv
aesInv_assertions.sv
aesInvTb.sv

// ==== Makefile ====
TOP   := aesInvTb
BUILD := obj_dir
LOG   := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir $(BUILD) -o $(TOP)

run: compile
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
